//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_sd_top
FILELIST ?= sd_dat.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/sd_dat_trace.txt
# Read trace for the SD DAT receiver, one test case per line
# Columns: name blocks_minus_one start_delay corrupt_nibble drain exp_error exp_count action
# corrupt_nibble counts nibbles over the whole transfer from zero, -1 for none
# action: none=0, flush_after_checks=1, card_busy_on_dat0=2, stop_then_flush=3
single_block     0  2   -1  1  0     0  0
multi_block      2  3   -1  1  0     0  0
card_busy        0  0   -1  0  0     0  2
crc_corrupt      0  1  100  1  1     0  0
overflow         2  1   -1  0  1  1024  1
stop_read        0  2   -1  0  0     0  3
read_after_stop  0  4   -1  1  0     0  0

//--- dv/tb_sd_top.sv
`timescale 1ns/1ps

module tb_sd_top;

    localparam int block_bytes = 512;
    localparam int fifo_almost = 4;

    logic clk;
    logic reset;
    logic start_read;
    logic stop;
    logic fifo_flush;
    logic rx_read;
    sd_pkg::blocks_t blocks;
    logic sd_clk;
    logic busy;
    logic error;
    logic card_busy;
    logic rx_empty;
    logic rx_almost_empty;
    sd_pkg::count_t rx_count;
    sd_pkg::byte_t rx_rdata;
    wire [3:0] sd_dat;

    logic card_oe;
    logic card_abort;
    logic [3:0] card_nibble;
    logic [8*16-1:0] case_name;
    int byte_errors;
    int count_errors;
    int flag_errors;
    int other_errors;

    // Pull-ups hold the lines high when the card leaves the bus
    assign sd_dat = card_oe ? card_nibble : 4'hf;

    sd_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One serial step of x^16 + x^12 + x^5 + 1
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic bit_in);
        logic feedback;
        feedback = crc[15] ^ bit_in;
        return {crc[14:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
    endfunction

    task automatic check_byte(input string what, input sd_pkg::byte_t expected,
                              input sd_pkg::byte_t actual);
        if (actual !== expected) begin
            byte_errors++;
            $display("ERR %0s %0s: expected %h actual %h", case_name, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input sd_pkg::count_t expected,
                               input sd_pkg::count_t actual);
        if (actual !== expected) begin
            count_errors++;
            $display("ERR %0s %0s: expected %0d actual %0d", case_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("ERR %0s %0s: expected %b actual %b", case_name, what, expected, actual);
        end
    endtask

    task automatic report_counts();
        $display("Errors: byte %0d, count %0d, flag %0d, other %0d",
                 byte_errors, count_errors, flag_errors, other_errors);
    endtask

    task automatic note_timeout(input string what);
        other_errors++;
        $display("Timeout in %0s while waiting for %0s", case_name, what);
    endtask

    // Returns 1 ns after the clk edge on which sd_clk fell
    task automatic wait_sd_fall();
        logic last;
        int n;
        n = 0;
        last = sd_clk;
        @(posedge clk);
        #1;
        while (!(last && !sd_clk) && n < 16) begin
            last = sd_clk;
            n++;
            @(posedge clk);
            #1;
        end
        if (n >= 16) begin
            note_timeout("a falling SD clock edge");
            // Without an SD clock the card model stops driving
            card_abort = 1'b1;
        end
    endtask

    task automatic drive_bus(input logic oe, input logic [3:0] nib);
        if (!card_abort) begin
            wait_sd_fall();
        end
        card_oe = oe && !card_abort;
        card_nibble = nib;
    endtask

    // Card side of a read with start bit, data, CRC16 per line and end bit
    task automatic send_blocks(input int count, input int delay, input int corrupt);
        logic [31:0] state;
        logic [15:0] crc [4];
        logic [3:0] nib;
        int nib_idx;
        state = 32'd6;
        nib_idx = 0;
        for (int b = 0; b < count; b++) begin
            for (int l = 0; l < 4; l++) begin
                crc[l] = '0;
            end
            repeat (delay) drive_bus(1'b0, 4'hf);
            drive_bus(1'b1, 4'h0);
            for (int i = 0; i < 2 * block_bytes; i++) begin
                if (i % 2 == 0) begin
                    state = next_random(state);
                end
                nib = (i % 2 == 0) ? state[7:4] : state[3:0];
                for (int l = 0; l < 4; l++) begin
                    crc[l] = crc_step(crc[l], nib[l]);
                end
                drive_bus(1'b1, (nib_idx == corrupt) ? ~nib : nib);
                nib_idx++;
            end
            for (int k = 15; k >= 0; k--) begin
                drive_bus(1'b1, {crc[3][k], crc[2][k], crc[1][k], crc[0][k]});
            end
            drive_bus(1'b1, 4'hf);
            drive_bus(1'b0, 4'hf);
        end
    endtask

    task automatic drain_check(input int total, input int corrupt);
        logic [31:0] state;
        sd_pkg::byte_t expected;
        int got;
        int idle;
        state = 32'd6;
        got = 0;
        idle = 0;
        while (got < total && idle < 2000) begin
            @(posedge clk);
            #1;
            if (rx_read) begin
                state = next_random(state);
                expected = state[7:0];
                if (corrupt >= 0 && corrupt / 2 == got) begin
                    expected ^= (corrupt % 2 == 0) ? 8'hf0 : 8'h0f;
                end
                check_byte($sformatf("byte %0d", got), expected, rx_rdata);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            rx_read = !rx_empty && got < total;
        end
        rx_read = 1'b0;
        if (got < total) begin
            note_timeout("bytes from the receive FIFO");
        end
    endtask

    task automatic stop_mid_read(input int delay);
        int n;
        repeat (delay + 40) wait_sd_fall();
        stop = 1'b1;
        @(posedge clk);
        #1;
        stop = 1'b0;
        n = 1;
        while (busy && n < 2) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_flag("busy after stop", 1'b0, busy);
        card_abort = 1'b1;
    endtask

    task automatic card_busy_case();
        int n;
        card_nibble = 4'he;
        card_oe = 1'b1;
        n = 0;
        while (!card_busy && n < 40) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_flag("card busy with DAT0 low", 1'b1, card_busy);
        card_oe = 1'b0;
        n = 0;
        while (card_busy && n < 40) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_flag("card busy after release", 1'b0, card_busy);
    endtask

    task automatic start_transfer(input sd_pkg::blocks_t nblocks);
        blocks = nblocks;
        start_read = 1'b1;
        @(posedge clk);
        #1;
        start_read = 1'b0;
        check_flag("busy after start", 1'b1, busy);
        check_flag("error cleared by start", 1'b0, error);
    endtask

    task automatic flush_fifo();
        fifo_flush = 1'b1;
        @(posedge clk);
        #1;
        fifo_flush = 1'b0;
        check_count("rx_count after flush", '0, rx_count);
        check_flag("empty after flush", 1'b1, rx_empty);
        check_flag("almost empty after flush", 1'b1, rx_almost_empty);
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (busy) begin
            note_timeout("busy to fall");
        end
    endtask

    task automatic run_case(input int nblocks_m1, input int delay, input int corrupt,
                            input int drain, input int exp_error, input int exp_count,
                            input int action);
        if (action == 2) begin
            card_busy_case();
        end else begin
            start_transfer(sd_pkg::blocks_t'(nblocks_m1));
            fork
                send_blocks(nblocks_m1 + 1, delay, corrupt);
                begin
                    if (drain != 0) begin
                        drain_check((nblocks_m1 + 1) * block_bytes, corrupt);
                    end
                end
                begin
                    if (action == 3) begin
                        stop_mid_read(delay);
                    end
                end
            join
            card_abort = 1'b0;
            if (action == 3) begin
                flush_fifo();
            end
            wait_busy_low();
            // Error is sticky and must still hold some cycles later
            repeat (8) @(posedge clk);
            #1;
        end
        check_flag("error", exp_error[0], error);
        check_count("rx_count", sd_pkg::count_t'(exp_count), rx_count);
        check_flag("rx_empty", exp_count == 0, rx_empty);
        check_flag("rx_almost_empty", exp_count <= fifo_almost, rx_almost_empty);
        if (action == 1) begin
            flush_fifo();
        end
    endtask

    initial begin
        int fd;
        int fields;
        int cases;
        logic [8*120-1:0] line;
        int nblocks_m1;
        int delay;
        int corrupt;
        int drain;
        int exp_error;
        int exp_count;
        int action;
        reset = 1'b1;
        start_read = 1'b0;
        stop = 1'b0;
        fifo_flush = 1'b0;
        blocks = '0;
        rx_read = 1'b0;
        card_oe = 1'b0;
        card_abort = 1'b0;
        card_nibble = 4'hf;
        case_name = "reset";
        byte_errors = 0;
        count_errors = 0;
        flag_errors = 0;
        other_errors = 0;
        cases = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("dv/sd_dat_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file dv/sd_dat_trace.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %d %d %d %d %d %d %d", case_name, nblocks_m1,
                                 delay, corrupt, drain, exp_error, exp_count, action);
                if (fields == 8) begin
                    run_case(nblocks_m1, delay, corrupt, drain, exp_error, exp_count, action);
                    cases++;
                end
            end
            $fclose(fd);
            if (cases == 0) begin
                $display("The trace file holds no test case");
                other_errors++;
            end
        end
        report_counts();
        if (byte_errors + count_errors + flag_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sd_dat.f
source/sd_pkg.sv
source/sd_scb.sv
source/fifo_bus.sv
source/sd_fifo.sv
source/sd_crc_16.sv
source/sd_clock.sv
source/sd_dat.sv
source/sd_top.sv
dv/tb_sd_top.sv

//--- source/fifo_bus.sv
`timescale 1ns/1ps

// Read side of the receive FIFO
// rx_rdata is valid one cycle after rx_read, reads while empty are ignored
interface fifo_bus;

    logic rx_read;
    sd_pkg::byte_t rx_rdata;
    logic rx_empty;
    logic rx_almost_empty;

    modport fifo (
        input rx_read,
        output rx_rdata,
        output rx_empty,
        output rx_almost_empty
    );

    modport reader (
        output rx_read,
        input rx_rdata,
        input rx_empty,
        input rx_almost_empty
    );

endinterface

//--- source/sd_clock.sv
`timescale 1ns/1ps

module sd_clock #(
    parameter int clock_div = 2
) (
    input logic clk,
    input logic reset,

    output logic sd_clk,
    output logic sd_clk_rising,
    output logic sd_clk_falling
);

    localparam int cnt_w = (clock_div > 1) ? $clog2(clock_div) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clock_div - 1);

    logic [cnt_w-1:0] div_cnt;

    // Strobes are registered with sd_clk so they line up with its edges
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            sd_clk <= 1'b0;
            sd_clk_rising <= 1'b0;
            sd_clk_falling <= 1'b0;
        end else begin
            sd_clk_rising <= 1'b0;
            sd_clk_falling <= 1'b0;
            if (div_cnt == cnt_last) begin
                div_cnt <= '0;
                sd_clk <= !sd_clk;
                sd_clk_rising <= !sd_clk;
                sd_clk_falling <= sd_clk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/sd_crc_16.sv
`timescale 1ns/1ps

module sd_crc_16 (
    input logic clk,
    input logic reset,

    input logic enable,
    input logic shift,
    input logic data,

    output logic [sd_pkg::crc_width-1:0] result
);

    logic feedback;

    assign feedback = result[sd_pkg::crc_width-1] ^ data;

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (enable) begin
            result <= {result[sd_pkg::crc_width-2:0], 1'b0}
                ^ (feedback ? sd_pkg::crc_poly : '0);
        end else if (shift) begin
            // Top bit presents the next CRC bit to compare
            result <= {result[sd_pkg::crc_width-2:0], 1'b0};
        end
    end

endmodule

//--- source/sd_dat.sv
`timescale 1ns/1ps

module sd_dat #(
    parameter int block_bytes = 512,
    parameter int fifo_depth = 1024,
    parameter int fifo_almost = 4
) (
    input logic clk,
    input logic reset,

    sd_scb.dat sd_scb,

    fifo_bus.fifo fifo_bus,

    input logic sd_clk_rising,
    input logic sd_clk_falling,

    inout wire [3:0] sd_dat
);

    // Nibble positions within a block, counted from 1
    localparam int data_last = 2 * block_bytes;
    localparam int crc_last = data_last + sd_pkg::crc_width;
    localparam int end_pos = crc_last + 1;
    localparam int cnt_w = $clog2(end_pos + 1);

    // Read path only, the host never drives the pads
    assign sd_dat = 4'bzzzz;

    logic [3:0] dat_in;

    always_ff @(posedge clk) begin
        dat_in <= sd_dat;
    end

    // Card holds DAT0 low while busy
    always_ff @(posedge clk) begin
        if (reset) begin
            sd_scb.card_busy <= 1'b0;
        end else if (sd_clk_falling) begin
            sd_scb.card_busy <= !dat_in[0];
        end
    end

    logic rx_full;
    logic rx_write;
    sd_pkg::byte_t rx_byte;
    logic fifo_reset;

    assign fifo_reset = reset || sd_scb.dat_fifo_flush;

    sd_fifo #(
        .fifo_depth(fifo_depth),
        .fifo_almost(fifo_almost)
    ) rx_fifo (
        .clk(clk),
        .reset(fifo_reset),
        .write(rx_write),
        .wdata(rx_byte),
        .full(rx_full),
        .almost_full(),
        .read(fifo_bus.rx_read),
        .rdata(fifo_bus.rx_rdata),
        .empty(fifo_bus.rx_empty),
        .almost_empty(fifo_bus.rx_almost_empty),
        .count(sd_scb.rx_count)
    );

    logic crc_clear;
    logic crc_reset;
    logic crc_enable;
    logic crc_shift;
    logic [3:0] crc_msb;

    assign crc_reset = reset || crc_clear;

    // One CRC16 per DAT line, fed from the nibble just captured
    for (genvar i = 0; i < 4; i++) begin : g_crc
        logic [sd_pkg::crc_width-1:0] result;

        sd_crc_16 crc (
            .clk(clk),
            .reset(crc_reset),
            .enable(crc_enable),
            .shift(crc_shift),
            .data(rx_byte[i]),
            .result(result)
        );

        assign crc_msb[i] = result[sd_pkg::crc_width-1];
    end

    typedef enum logic [1:0] {
        st_idle,
        st_rx_wait,
        st_rx
    } state_t;

    state_t state;
    state_t next_state;
    logic [cnt_w-1:0] nibble_cnt;
    sd_pkg::blocks_t blocks_left;

    always_ff @(posedge clk) begin
        if (reset || sd_scb.dat_stop) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    assign sd_scb.dat_busy = (state != st_idle);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (sd_scb.dat_start_read) begin
                    next_state = st_rx_wait;
                end
            end
            st_rx_wait: begin
                if (sd_clk_rising && !dat_in[0]) begin
                    next_state = st_rx;
                end
            end
            st_rx: begin
                if (sd_clk_rising && nibble_cnt == cnt_w'(end_pos)) begin
                    next_state = (blocks_left == '0) ? st_idle : st_rx_wait;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        rx_write <= 1'b0;
        crc_clear <= 1'b0;
        crc_enable <= 1'b0;
        crc_shift <= 1'b0;

        if (reset) begin
            sd_scb.dat_error <= 1'b0;
            nibble_cnt <= '0;
            blocks_left <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (sd_scb.dat_start_read) begin
                        sd_scb.dat_error <= 1'b0;
                        blocks_left <= sd_scb.dat_blocks;
                    end
                end
                st_rx_wait: begin
                    if (sd_clk_rising && !dat_in[0]) begin
                        nibble_cnt <= cnt_w'(1);
                        crc_clear <= 1'b1;
                    end
                end
                st_rx: begin
                    if (sd_clk_rising) begin
                        nibble_cnt <= nibble_cnt + 1'b1;
                        if (nibble_cnt <= cnt_w'(data_last)) begin
                            // High nibble first, byte complete on even positions
                            rx_byte <= {rx_byte[3:0], dat_in};
                            crc_enable <= 1'b1;
                            if (!nibble_cnt[0]) begin
                                if (rx_full) begin
                                    sd_scb.dat_error <= 1'b1;
                                end else begin
                                    rx_write <= 1'b1;
                                end
                            end
                        end else if (nibble_cnt <= cnt_w'(crc_last)) begin
                            crc_shift <= 1'b1;
                            if (crc_msb != dat_in) begin
                                sd_scb.dat_error <= 1'b1;
                            end
                        end else begin
                            // End bit, all lines high
                            if (dat_in != 4'hf) begin
                                sd_scb.dat_error <= 1'b1;
                            end
                            if (blocks_left != '0) begin
                                blocks_left <= blocks_left - 1'b1;
                            end
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/sd_fifo.sv
`timescale 1ns/1ps

module sd_fifo #(
    parameter int fifo_depth = 1024,
    parameter int fifo_almost = 4
) (
    input logic clk,
    input logic reset,

    input logic write,
    input sd_pkg::byte_t wdata,
    output logic full,
    output logic almost_full,

    input logic read,
    output sd_pkg::byte_t rdata,
    output logic empty,
    output logic almost_empty,

    output sd_pkg::count_t count
);

    localparam int addr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam logic [addr_w-1:0] last_addr = addr_w'(fifo_depth - 1);

    sd_pkg::byte_t mem [fifo_depth];

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic do_write;
    logic do_read;

    // Writes when full and reads when empty are dropped
    assign do_write = write && !full;
    assign do_read = read && !empty;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
        if (do_read) begin
            rdata <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = (count == sd_pkg::count_t'(fifo_depth));
    assign almost_full = (count >= sd_pkg::count_t'(fifo_depth - fifo_almost));
    assign empty = (count == '0);
    assign almost_empty = (count <= sd_pkg::count_t'(fifo_almost));

endmodule

//--- source/sd_pkg.sv
package sd_pkg;

    // CRC16 per DAT line, x^16 + x^12 + x^5 + 1, register starts at zero
    localparam int crc_width = 16;
    localparam logic [crc_width-1:0] crc_poly = 16'h1021;

    // Number of blocks minus one, as requested by the host
    typedef logic [7:0] blocks_t;

    typedef logic [7:0] byte_t;

    // One bit wider than the FIFO address, fits a depth of up to 2048
    typedef logic [11:0] count_t;

endpackage

//--- source/sd_scb.sv
`timescale 1ns/1ps

// Control and status between the host side and the DAT receiver
interface sd_scb;

    logic dat_start_read;
    logic dat_stop;
    logic dat_fifo_flush;
    sd_pkg::blocks_t dat_blocks;

    logic dat_busy;
    logic dat_error;
    logic card_busy;
    sd_pkg::count_t rx_count;

    modport host (
        output dat_start_read,
        output dat_stop,
        output dat_fifo_flush,
        output dat_blocks,
        input dat_busy,
        input dat_error,
        input card_busy,
        input rx_count
    );

    modport dat (
        input dat_start_read,
        input dat_stop,
        input dat_fifo_flush,
        input dat_blocks,
        output dat_busy,
        output dat_error,
        output card_busy,
        output rx_count
    );

endinterface

//--- source/sd_top.sv
`timescale 1ns/1ps

module sd_top #(
    parameter int block_bytes = 512,
    parameter int fifo_depth = 1024,
    parameter int fifo_almost = 4,
    parameter int clock_div = 2
) (
    input logic clk,
    input logic reset,

    output logic sd_clk,
    inout wire [3:0] sd_dat,

    input logic start_read,
    input logic stop,
    input logic fifo_flush,
    input sd_pkg::blocks_t blocks,
    output logic busy,
    output logic error,
    output logic card_busy,
    output sd_pkg::count_t rx_count,

    input logic rx_read,
    output sd_pkg::byte_t rx_rdata,
    output logic rx_empty,
    output logic rx_almost_empty
);

    sd_scb scb ();
    fifo_bus rx_bus ();

    logic sd_clk_rising;
    logic sd_clk_falling;

    assign scb.dat_start_read = start_read;
    assign scb.dat_stop = stop;
    assign scb.dat_fifo_flush = fifo_flush;
    assign scb.dat_blocks = blocks;
    assign busy = scb.dat_busy;
    assign error = scb.dat_error;
    assign card_busy = scb.card_busy;
    assign rx_count = scb.rx_count;

    assign rx_bus.rx_read = rx_read;
    assign rx_rdata = rx_bus.rx_rdata;
    assign rx_empty = rx_bus.rx_empty;
    assign rx_almost_empty = rx_bus.rx_almost_empty;

    sd_clock #(
        .clock_div(clock_div)
    ) clock_inst (
        .clk(clk),
        .reset(reset),
        .sd_clk(sd_clk),
        .sd_clk_rising(sd_clk_rising),
        .sd_clk_falling(sd_clk_falling)
    );

    sd_dat #(
        .block_bytes(block_bytes),
        .fifo_depth(fifo_depth),
        .fifo_almost(fifo_almost)
    ) dat_inst (
        .clk(clk),
        .reset(reset),
        .sd_scb(scb.dat),
        .fifo_bus(rx_bus.fifo),
        .sd_clk_rising(sd_clk_rising),
        .sd_clk_falling(sd_clk_falling),
        .sd_dat(sd_dat)
    );

endmodule
